//--- hw/mult_kernel_adders.sv
//////////////////////////////
// Kernel adder tree
// 16x16 lane merge, 32x16 adder and 32x32 adder
//////////////////////////////

`timescale 1ns/100ps

module mult_kernel_adders import simd_mult_pkg::*; (
  input  kprod_arr_t  prod_i,
  input  mult_mode_e  mode_i,
  input  logic [1:0]  add_mode_i,
  input  logic        accum_sub_i,
  input  word_t       rd_val_i,
  input  wide_t       imd_q_i,
  input  mult_state_e state_i,
  output word_t       lane16_lo_o,
  output word_t       lane16_hi_o,
  output word_t       sum32x16_o,
  output wide_t       wide_o,
  output word_t       word32_o
);

  // Merge four byte products into one signed 16x16 product
  function automatic word_t merge16(word_t p00, word_t p01, word_t p10, word_t p11);
    return p00 + (p01 << 8) + (p10 << 8) + (p11 << 16);
  endfunction

  word_t pext [8];
  word_t lane_lo;
  word_t lane_hi;
  logic  narrow;
  logic  lo_ext;
  logic  carry_in;
  wide_t add_x;
  wide_t add_y;
  wide_t sum48;
  wide_t acc_x;
  wide_t acc_y;
  wide_t acc_sum;

  assign narrow = (mode_i == M8X8);

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      pext[i] = {{14{prod_i[i][17]}}, prod_i[i]};
    end
  end

  //////////////////////////////
  // 16x16 kernel adders
  //////////////////////////////

  // Byte mode adds the four diagonal products into the low lane
  assign lane_lo = narrow ? pext[0] + pext[3] + pext[4] + pext[7]
                          : merge16(pext[0], pext[1], pext[2], pext[3]);
  assign lane_hi = narrow ? '0 : merge16(pext[4], pext[5], pext[6], pext[7]);

  assign lane16_lo_o = lane_lo;
  assign lane16_hi_o = lane_hi;

  //////////////////////////////
  // 32x16 kernel adders
  //////////////////////////////

  // a_lo times b_lo is unsigned in the first SMMUL cycle
  assign lo_ext   = (mode_i == M32X32 && state_i == ST_LOWER) ? 1'b0 : lane_lo[31];
  assign carry_in = add_mode_i[0] & accum_sub_i;

  always_comb begin
    if (add_mode_i[0]) begin
      add_x = {{16{lane_hi[31]}}, lane_hi};
      add_y = {{16{lane_lo[31]}}, lane_lo};
      // Two's complement subtract of the bottom lane
      if (accum_sub_i) begin
        add_y = ~add_y;
      end
    end else begin
      add_x = {lane_hi, 16'h0000};
      add_y = {{16{lo_ext}}, lane_lo};
    end
  end

  assign sum48      = add_x + add_y + {47'd0, carry_in};
  assign sum32x16_o = sum48[31:0];
  assign wide_o     = sum48;

  //////////////////////////////
  // 32x32 kernel adders
  //////////////////////////////

  always_comb begin
    if (add_mode_i[1]) begin
      acc_x = {rd_val_i, 16'h0000};
      acc_y = {sum48[31:0], 16'h0000};
    end else begin
      // Upper partial plus lower partial shifted down by 16
      acc_x = sum48;
      acc_y = {{16{imd_q_i[47]}}, imd_q_i[47:16]};
    end
  end

  assign acc_sum  = acc_x + acc_y;
  assign word32_o = acc_sum[47:16];

endmodule

//--- hw/mult_kernel_array.sv
//////////////////////////////
// Kernel multiplier array
// Lane selection, sign decoding and eight 9x9 products
//////////////////////////////

`timescale 1ns/100ps

module mult_kernel_array import simd_mult_pkg::*; (
  input  word_t       op_a_i,
  input  word_t       op_b_i,
  input  mult_mode_e  mode_i,
  input  mult_state_e state_i,
  output kprod_arr_t  prod_o
);

  byte_t      a_byte [4];
  byte_t      b_byte [4];
  logic [3:0] a_sgn;
  logic [3:0] b_sgn;
  logic       b_upper;

  // Second SMMUL cycle works on the top half of b
  assign b_upper = (mode_i == M32X32) && (state_i == ST_UPPER);

  //////////////////////////////
  // Lane selection
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      a_byte[i] = op_a_i[8*i +: 8];
    end

    if (mode_i == M32X32) begin
      // Both kernels share one b half
      b_byte[0] = b_upper ? op_b_i[23:16] : op_b_i[7:0];
      b_byte[1] = b_upper ? op_b_i[31:24] : op_b_i[15:8];
      b_byte[2] = b_byte[0];
      b_byte[3] = b_byte[1];
    end else begin
      for (int i = 0; i < 4; i++) begin
        b_byte[i] = op_b_i[8*i +: 8];
      end
    end
  end

  //////////////////////////////
  // Sign decoder
  //////////////////////////////

  // Only the top byte of a lane carries a sign
  always_comb begin
    unique case (mode_i)
      M16X16: begin
        a_sgn = {a_byte[3][7], 1'b0, a_byte[1][7], 1'b0};
        b_sgn = {b_byte[3][7], 1'b0, b_byte[1][7], 1'b0};
      end
      M32X32: begin
        a_sgn = {a_byte[3][7], 3'b000};
        // Lower half of b is unsigned
        b_sgn = b_upper ? {b_byte[3][7], 1'b0, b_byte[1][7], 1'b0} : 4'b0000;
      end
      default: begin
        a_sgn = {a_byte[3][7], a_byte[2][7], a_byte[1][7], a_byte[0][7]};
        b_sgn = {b_byte[3][7], b_byte[2][7], b_byte[1][7], b_byte[0][7]};
      end
    endcase
  end

  //////////////////////////////
  // Kernel products
  //////////////////////////////

  // Two kernels of four products each
  for (genvar k = 0; k < 2; k++) begin : g_kernel
    for (genvar i = 0; i < 2; i++) begin : g_a
      for (genvar j = 0; j < 2; j++) begin : g_b
        assign prod_o[4*k + 2*i + j] =
          $signed({a_sgn[2*k+i], a_byte[2*k+i]}) * $signed({b_sgn[2*k+j], b_byte[2*k+j]});
      end
    end
  end

endmodule

//--- hw/mult_op_decode.sv
//////////////////////////////
// Operation decoder
// Kernel mode and adder controls per operation
//////////////////////////////

`timescale 1ns/100ps

module mult_op_decode import simd_mult_pkg::*; (
  input  mult_op_e   op_i,
  output mult_mode_e mode_o,
  output logic [1:0] add_mode_o,
  output logic       accum_sub_o,
  output logic       multi_cycle_o
);

  // add_mode bit 0 joins both lanes in the 32x16 adder
  // add_mode bit 1 adds rd_val in the 32x32 adder
  always_comb begin
    mode_o        = M8X8;
    add_mode_o    = 2'b00;
    accum_sub_o   = 1'b0;
    multi_cycle_o = 1'b0;

    unique case (op_i)
      OP_KHM8: begin
        mode_o = M8X8;
      end
      OP_KHM16, OP_SMBB16, OP_SMTT16: begin
        mode_o = M16X16;
      end
      OP_SMDS: begin
        mode_o      = M16X16;
        add_mode_o  = 2'b01;
        accum_sub_o = 1'b1;
      end
      OP_SMAQA: begin
        mode_o     = M8X8;
        add_mode_o = 2'b11;
      end
      OP_SMMUL: begin
        mode_o        = M32X32;
        multi_cycle_o = 1'b1;
      end
      default: begin
        mode_o = M8X8;
      end
    endcase
  end

endmodule

//--- hw/mult_result_sat.sv
//////////////////////////////
// Lane saturation and result mux
//////////////////////////////

`timescale 1ns/100ps

module mult_result_sat import simd_mult_pkg::*; (
  input  mult_op_e   op_i,
  input  logic       en_i,
  input  word_t      op_a_i,
  input  word_t      op_b_i,
  input  kprod_arr_t prod_i,
  input  word_t      lane16_lo_i,
  input  word_t      lane16_hi_i,
  input  word_t      sum32x16_i,
  input  word_t      word32_i,
  output word_t      result_o,
  output logic       set_ov_o
);

  logic [3:0] sat8;
  logic [1:0] sat16;
  byte_t      q7_lane [4];
  half_t      q15_lane [2];

  //////////////////////////////
  // Saturation detect
  //////////////////////////////

  // Most negative value is the complement of the max
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      sat8[i] = (op_a_i[8*i +: 8] == ~Q7_MAX) && (op_b_i[8*i +: 8] == ~Q7_MAX);
    end
    for (int i = 0; i < 2; i++) begin
      sat16[i] = (op_a_i[16*i +: 16] == ~Q15_MAX) && (op_b_i[16*i +: 16] == ~Q15_MAX);
    end
  end

  // Byte lanes come from the diagonal kernel products
  assign q7_lane[0] = sat8[0] ? Q7_MAX : prod_i[0][14:7];
  assign q7_lane[1] = sat8[1] ? Q7_MAX : prod_i[3][14:7];
  assign q7_lane[2] = sat8[2] ? Q7_MAX : prod_i[4][14:7];
  assign q7_lane[3] = sat8[3] ? Q7_MAX : prod_i[7][14:7];

  assign q15_lane[0] = sat16[0] ? Q15_MAX : lane16_lo_i[30:15];
  assign q15_lane[1] = sat16[1] ? Q15_MAX : lane16_hi_i[30:15];

  always_comb begin
    set_ov_o = 1'b0;
    if (op_i == OP_KHM8) begin
      set_ov_o = en_i & (|sat8);
    end else if (op_i == OP_KHM16) begin
      set_ov_o = en_i & (|sat16);
    end
  end

  //////////////////////////////
  // Final result mux
  //////////////////////////////

  always_comb begin
    unique case (op_i)
      OP_KHM8:           result_o = {q7_lane[3], q7_lane[2], q7_lane[1], q7_lane[0]};
      OP_KHM16:          result_o = {q15_lane[1], q15_lane[0]};
      OP_SMBB16:         result_o = lane16_lo_i;
      OP_SMTT16:         result_o = lane16_hi_i;
      OP_SMDS:           result_o = sum32x16_i;
      OP_SMAQA, OP_SMMUL: result_o = word32_i;
      default:           result_o = '0;
    endcase
  end

endmodule

//--- hw/mult_sequencer.sv
//////////////////////////////
// Multiplier sequencer
// LOWER/UPPER FSM and intermediate product register
//////////////////////////////

`timescale 1ns/100ps

module mult_sequencer import simd_mult_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        en_i,
  input  logic        multi_cycle_i,
  input  logic        ready_i,
  input  wide_t       wide_i,
  output mult_state_e state_o,
  output wide_t       imd_q_o,
  output logic        valid_o
);

  mult_state_e state_q;
  mult_state_e state_d;
  wide_t       imd_q;
  logic        imd_load;

  // Lower partial is captured on the first enabled cycle
  assign imd_load = en_i & multi_cycle_i & (state_q == ST_LOWER);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_LOWER: begin
        if (en_i && multi_cycle_i) begin
          state_d = ST_UPPER;
        end
      end
      ST_UPPER: begin
        // Hold the result until the consumer takes it
        if (ready_i) begin
          state_d = ST_LOWER;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_LOWER;
      imd_q   <= '0;
    end else begin
      state_q <= state_d;
      if (imd_load) begin
        imd_q <= wide_i;
      end
    end
  end

  assign valid_o = en_i & (~multi_cycle_i | (state_q == ST_UPPER));
  assign state_o = state_q;
  assign imd_q_o = imd_q;

endmodule

//--- hw/simd_mult.sv
//////////////////////////////
// Packed-SIMD multiplier top level
// Decoder, kernels, adder tree, result stage and sequencer
//////////////////////////////

`timescale 1ns/100ps

module simd_mult import simd_mult_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     en_i,
  input  mult_op_e op_i,
  input  word_t    op_a_i,
  input  word_t    op_b_i,
  input  word_t    rd_val_i,
  input  logic     ready_i,
  output word_t    result_o,
  output logic     valid_o,
  output logic     set_ov_o
);

  mult_mode_e  mode;
  logic [1:0]  add_mode;
  logic        accum_sub;
  logic        multi_cycle;
  mult_state_e state;
  wide_t       imd_q;
  kprod_arr_t  prod;
  word_t       lane16_lo;
  word_t       lane16_hi;
  word_t       sum32x16;
  wide_t       wide;
  word_t       word32;

  mult_op_decode u_decode (
    .op_i          (op_i),
    .mode_o        (mode),
    .add_mode_o    (add_mode),
    .accum_sub_o   (accum_sub),
    .multi_cycle_o (multi_cycle)
  );

  mult_kernel_array u_kernels (
    .op_a_i  (op_a_i),
    .op_b_i  (op_b_i),
    .mode_i  (mode),
    .state_i (state),
    .prod_o  (prod)
  );

  mult_kernel_adders u_adders (
    .prod_i      (prod),
    .mode_i      (mode),
    .add_mode_i  (add_mode),
    .accum_sub_i (accum_sub),
    .rd_val_i    (rd_val_i),
    .imd_q_i     (imd_q),
    .state_i     (state),
    .lane16_lo_o (lane16_lo),
    .lane16_hi_o (lane16_hi),
    .sum32x16_o  (sum32x16),
    .wide_o      (wide),
    .word32_o    (word32)
  );

  mult_result_sat u_result (
    .op_i        (op_i),
    .en_i        (en_i),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .prod_i      (prod),
    .lane16_lo_i (lane16_lo),
    .lane16_hi_i (lane16_hi),
    .sum32x16_i  (sum32x16),
    .word32_i    (word32),
    .result_o    (result_o),
    .set_ov_o    (set_ov_o)
  );

  mult_sequencer u_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .multi_cycle_i (multi_cycle),
    .ready_i       (ready_i),
    .wide_i        (wide),
    .state_o       (state),
    .imd_q_o       (imd_q),
    .valid_o       (valid_o)
  );

endmodule

//--- hw/simd_mult_pkg.sv
//////////////////////////////
// Packed-SIMD multiplier definitions
// Widths, lane vector types, saturation values and enums
//////////////////////////////

package simd_mult_pkg;

  //////////////////////////////
  // Widths and lane types
  //////////////////////////////

  // Operand width, the lane structure is fixed around it
  localparam int XLEN = 32;

  // One operand or result word
  typedef logic [XLEN-1:0] word_t;

  // One 8-bit lane
  typedef logic [7:0] byte_t;

  // One 16-bit lane
  typedef logic [15:0] half_t;

  // Signed 9x9 kernel product
  typedef logic [17:0] kprod_t;

  // All eight kernel products, index is 4*kernel + 2*a_byte + b_byte
  typedef kprod_t [7:0] kprod_arr_t;

  // 32x16 partial product
  typedef logic [47:0] wide_t;

  //////////////////////////////
  // Saturation values
  //////////////////////////////

  localparam byte_t Q7_MAX  = 8'h7f;
  localparam half_t Q15_MAX = 16'h7fff;

  //////////////////////////////
  // Enums
  //////////////////////////////

  typedef enum logic [2:0] {
    OP_KHM8,
    OP_KHM16,
    OP_SMBB16,
    OP_SMTT16,
    OP_SMDS,
    OP_SMAQA,
    OP_SMMUL
  } mult_op_e;

  // Kernel operand arrangement
  typedef enum logic [1:0] {
    M8X8,
    M16X16,
    M32X32
  } mult_mode_e;

  // Sequencer state for the two-cycle 32x32 product
  typedef enum logic {
    ST_LOWER,
    ST_UPPER
  } mult_state_e;

endpackage

//--- simd_mult.f
hw/simd_mult_pkg.sv
hw/mult_op_decode.sv
hw/mult_kernel_array.sv
hw/mult_kernel_adders.sv
hw/mult_result_sat.sv
hw/mult_sequencer.sv
hw/simd_mult.sv
tests/simd_mult_props.sv
tests/tb_simd_mult.sv

//--- tests/simd_mult_props.sv
//////////////////////////////
// Protocol checks for the multiplier
// Valid, ready and overflow behavior, bound to the top level
//////////////////////////////

`timescale 1ns/100ps

module simd_mult_props import simd_mult_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  en_i,
  input logic  ready_i,
  input logic  valid_i,
  input logic  set_ov_i,
  input logic  multi_cycle_i,
  input word_t result_i
);

  int fail_cnt = 0;

  // Result holds while the consumer stalls a 32x32 product
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && multi_cycle_i && !ready_i |=> valid_i && $stable(result_i)) else begin
    fail_cnt++;
    $error("valid_o or result_o changed while ready_i was low");
  end

  // Idle unit shows no result and no overflow
  a_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !en_i |-> !valid_i && !set_ov_i) else begin
    fail_cnt++;
    $error("valid_o or set_ov_o high while en_i was low");
  end

  // SMMUL valid rises exactly one cycle after en_i
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(en_i) && multi_cycle_i |-> !valid_i ##1 valid_i) else begin
    fail_cnt++;
    $error("SMMUL valid_o did not rise exactly one cycle after en_i");
  end

endmodule

bind simd_mult simd_mult_props u_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .en_i          (en_i),
  .ready_i       (ready_i),
  .valid_i       (valid_o),
  .set_ov_i      (set_ov_o),
  .multi_cycle_i (multi_cycle),
  .result_i      (result_o)
);

//--- tests/tb_simd_mult.sv
//////////////////////////////
// Multiplier testbench
// Clock, reset, random stimulus, reference model,
// result checks, watchdog and report
//////////////////////////////

`timescale 1ns/100ps

module tb_simd_mult import simd_mult_pkg::*; ();

  localparam int NUM_TESTS    = 4;
  localparam int OPS_PER_TEST = 40;

  logic     clk_i;
  logic     rst_ni;
  logic     en_i;
  logic     ready_i;
  logic     valid_o;
  logic     set_ov_o;
  logic     exp_ov;
  mult_op_e op_i;
  word_t    op_a_i;
  word_t    op_b_i;
  word_t    rd_val_i;
  word_t    result_o;
  word_t    exp_res;
  integer   seed;
  int       errors;
  int       test_errors;

  // Two operations per test that alternate by iteration
  mult_op_e op_pair [4][2] = '{'{OP_KHM8, OP_KHM16}, '{OP_SMBB16, OP_SMTT16},
                               '{OP_SMDS, OP_SMAQA}, '{OP_SMMUL, OP_SMMUL}};

  simd_mult uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // At most four cycles per operation plus reset and margin
  initial begin
    #((NUM_TESTS * OPS_PER_TEST * 4 + 50) * 100);
    $display("Timeout: the tests did not finish in time");
    $display("Test failed");
    $finish;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Signed lane i of width w
  function automatic int lane(word_t v, int i, int w);
    return $signed(v << (32 - w * (i + 1))) >>> (32 - w);
  endfunction

  // Expected result from the operation definitions
  function automatic word_t expect_result(mult_op_e f_op, word_t a, word_t b, word_t rd,
                                          output logic ov);
    int     w;
    int     p;
    longint r;
    ov = 1'b0;
    r  = (f_op == OP_SMAQA) ? longint'(rd) : 0;
    w  = (f_op == OP_KHM8) ? 8 : 16;
    case (f_op)
      OP_KHM8, OP_KHM16: begin
        for (int i = 0; i < 32 / w; i++) begin
          p = (lane(a, i, w) * lane(b, i, w)) >>> (w - 1);
          // Only min times min leaves the Q range
          if (p == 1 << (w - 1)) begin
            ov = 1'b1;
            p  = p - 1;
          end
          r |= longint'(p & ((1 << w) - 1)) << (w * i);
        end
      end
      OP_SMBB16: r = lane(a, 0, 16) * lane(b, 0, 16);
      OP_SMTT16: r = lane(a, 1, 16) * lane(b, 1, 16);
      OP_SMDS:   r = lane(a, 1, 16) * lane(b, 1, 16) - lane(a, 0, 16) * lane(b, 0, 16);
      OP_SMAQA: begin
        for (int i = 0; i < 4; i++) begin
          r += lane(a, i, 8) * lane(b, i, 8);
        end
      end
      // SMMUL keeps the upper word of the 64-bit product
      default: r = (longint'($signed(a)) * longint'($signed(b))) >>> 32;
    endcase
    return r[31:0];
  endfunction

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////

  initial begin
    seed     = 10437;
    errors   = 0;
    rst_ni   = 1'b0;
    en_i     = 1'b0;
    ready_i  = 1'b0;
    op_i     = OP_KHM8;
    op_a_i   = '0;
    op_b_i   = '0;
    rd_val_i = '0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int t = 0; t < NUM_TESTS; t++) begin
      test_errors = 0;
      for (int n = 0; n < OPS_PER_TEST; n++) begin
        @(negedge clk_i);
        en_i     = 1'b1;
        op_i     = op_pair[t][n % 2];
        op_a_i   = $random(seed);
        op_b_i   = $random(seed);
        rd_val_i = $random(seed);
        // Most negative lane in both operands
        if (n % 3 == 0) begin
          if (op_i == OP_KHM8) begin
            op_a_i[8*(n/6%4) +: 8] = 8'h80;
            op_b_i[8*(n/6%4) +: 8] = 8'h80;
          end else begin
            op_a_i[16*(n/6%2) +: 16] = 16'h8000;
            op_b_i[16*(n/6%2) +: 16] = 16'h8000;
          end
        end
        exp_res = expect_result(op_i, op_a_i, op_b_i, rd_val_i, exp_ov);
        #1;
        // Single-cycle results come with en_i and SMMUL one cycle later
        assert (valid_o == (op_i != OP_SMMUL)) else begin
          $display("error %0t: %s valid_o was %b in the first enabled cycle", $time,
                   op_i.name(), valid_o);
          test_errors++;
        end
        @(negedge clk_i);
        assert (valid_o && result_o == exp_res && set_ov_o == exp_ov) else begin
          $display("error %0t: %s gave %h ov %b valid %b, expected %h ov %b", $time,
                   op_i.name(), result_o, set_ov_o, valid_o, exp_res, exp_ov);
          test_errors++;
        end
        // Random back-pressure before the result is taken
        if ($random(seed) & 1) begin
          @(negedge clk_i);
        end
        ready_i = 1'b1;
        @(negedge clk_i);
        en_i    = 1'b0;
        ready_i = 1'b0;
      end
      $display("test %0d (%s/%s): %0d operations, %0d errors", t + 1, op_pair[t][0].name(),
               op_pair[t][1].name(), OPS_PER_TEST, test_errors);
      errors += test_errors;
    end

    $display("Tests: %0d, check errors: %0d, property failures: %0d", NUM_TESTS, errors,
             uut.u_props.fail_cnt);
    if (errors == 0 && uut.u_props.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
